//--- source/dec_pkg.sv
package dec_pkg;

   localparam int DATA_W = 32;
   localparam int REG_W  = 5;
   localparam int CSR_W  = 14;
   localparam int EXC_W  = 6;

   typedef enum logic [3:0] {
      ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_AND, ALU_OR,
      ALU_NOR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
   } alu_op_t;

   // stores sit above the loads
   typedef enum logic [3:0] {
      LSU_LD_B, LSU_LD_H, LSU_LD_W, LSU_LD_BU, LSU_LD_HU,
      LSU_ST_B, LSU_ST_H, LSU_ST_W
   } lsu_op_t;

   // conditional branches first, then the unconditional ones
   typedef enum logic [3:0] {
      BRU_BEQ, BRU_BNE, BRU_BLT, BRU_BGE, BRU_BLTU, BRU_BGEU,
      BRU_B, BRU_BL, BRU_JIRL
   } bru_op_t;

   typedef enum logic [3:0] {
      U_ALU, U_LSU, U_BRU, U_MUL, U_CSR, U_ERTN, U_SYS, U_BRK, U_NONE
   } unit_t;

   // immediate kinds
   localparam logic [2:0] IMM_ZERO = 3'd0;
   localparam logic [2:0] IMM_SI12 = 3'd1;
   localparam logic [2:0] IMM_UI12 = 3'd2;
   localparam logic [2:0] IMM_UI5  = 3'd3;
   localparam logic [2:0] IMM_SI20 = 3'd4;

   localparam logic [EXC_W-1:0] EXC_SYS = 6'h0B;
   localparam logic [EXC_W-1:0] EXC_BRK = 6'h0C;
   localparam logic [EXC_W-1:0] EXC_INE = 6'h0D;

   //////////////////////////////
   // LA32 opcode match and mask
   //////////////////////////////

   typedef struct packed {
      logic [31:0] match;
      logic [31:0] mask;
   } opc_t;

   localparam logic [31:0] MSK_3R   = 32'hFFFF_8000;
   localparam logic [31:0] MSK_I12  = 32'hFFC0_0000;
   localparam logic [31:0] MSK_I20  = 32'hFE00_0000;
   localparam logic [31:0] MSK_I26  = 32'hFC00_0000;
   // csrrd and csrwr also pin the rj field
   localparam logic [31:0] MSK_CSRJ = 32'hFF00_03E0;
   localparam logic [31:0] MSK_CSR  = 32'hFF00_0000;
   localparam logic [31:0] MSK_FULL = 32'hFFFF_FFFF;

   localparam opc_t OPC_ADD_W     = '{32'h0010_0000, MSK_3R};
   localparam opc_t OPC_SUB_W     = '{32'h0011_0000, MSK_3R};
   localparam opc_t OPC_SLT       = '{32'h0012_0000, MSK_3R};
   localparam opc_t OPC_SLTU      = '{32'h0012_8000, MSK_3R};
   localparam opc_t OPC_NOR       = '{32'h0014_0000, MSK_3R};
   localparam opc_t OPC_AND       = '{32'h0014_8000, MSK_3R};
   localparam opc_t OPC_OR        = '{32'h0015_0000, MSK_3R};
   localparam opc_t OPC_XOR       = '{32'h0015_8000, MSK_3R};
   localparam opc_t OPC_SLL_W     = '{32'h0017_0000, MSK_3R};
   localparam opc_t OPC_SRL_W     = '{32'h0017_8000, MSK_3R};
   localparam opc_t OPC_SRA_W     = '{32'h0018_0000, MSK_3R};
   localparam opc_t OPC_MUL_W     = '{32'h001C_0000, MSK_3R};
   localparam opc_t OPC_MULH_W    = '{32'h001C_8000, MSK_3R};
   localparam opc_t OPC_MULH_WU   = '{32'h001D_0000, MSK_3R};
   localparam opc_t OPC_BREAK     = '{32'h002A_0000, MSK_3R};
   localparam opc_t OPC_SYSCALL   = '{32'h002B_0000, MSK_3R};
   localparam opc_t OPC_SLLI_W    = '{32'h0040_8000, MSK_3R};
   localparam opc_t OPC_SRLI_W    = '{32'h0044_8000, MSK_3R};
   localparam opc_t OPC_SRAI_W    = '{32'h0048_8000, MSK_3R};
   localparam opc_t OPC_SLTI      = '{32'h0200_0000, MSK_I12};
   localparam opc_t OPC_SLTUI     = '{32'h0240_0000, MSK_I12};
   localparam opc_t OPC_ADDI_W    = '{32'h0280_0000, MSK_I12};
   localparam opc_t OPC_ANDI      = '{32'h0340_0000, MSK_I12};
   localparam opc_t OPC_ORI       = '{32'h0380_0000, MSK_I12};
   localparam opc_t OPC_XORI      = '{32'h03C0_0000, MSK_I12};
   localparam opc_t OPC_CSRRD     = '{32'h0400_0000, MSK_CSRJ};
   localparam opc_t OPC_CSRWR     = '{32'h0400_0020, MSK_CSRJ};
   localparam opc_t OPC_CSRXCHG   = '{32'h0400_0000, MSK_CSR};
   localparam opc_t OPC_ERTN      = '{32'h0648_3800, MSK_FULL};
   localparam opc_t OPC_LU12I_W   = '{32'h1400_0000, MSK_I20};
   localparam opc_t OPC_PCADDU12I = '{32'h1C00_0000, MSK_I20};
   localparam opc_t OPC_LD_B      = '{32'h2800_0000, MSK_I12};
   localparam opc_t OPC_LD_H      = '{32'h2840_0000, MSK_I12};
   localparam opc_t OPC_LD_W      = '{32'h2880_0000, MSK_I12};
   localparam opc_t OPC_ST_B      = '{32'h2900_0000, MSK_I12};
   localparam opc_t OPC_ST_H      = '{32'h2940_0000, MSK_I12};
   localparam opc_t OPC_ST_W      = '{32'h2980_0000, MSK_I12};
   localparam opc_t OPC_LD_BU     = '{32'h2A00_0000, MSK_I12};
   localparam opc_t OPC_LD_HU     = '{32'h2A40_0000, MSK_I12};
   localparam opc_t OPC_JIRL      = '{32'h4C00_0000, MSK_I26};
   localparam opc_t OPC_B         = '{32'h5000_0000, MSK_I26};
   localparam opc_t OPC_BL        = '{32'h5400_0000, MSK_I26};
   localparam opc_t OPC_BEQ       = '{32'h5800_0000, MSK_I26};
   localparam opc_t OPC_BNE       = '{32'h5C00_0000, MSK_I26};
   localparam opc_t OPC_BLT       = '{32'h6000_0000, MSK_I26};
   localparam opc_t OPC_BGE       = '{32'h6400_0000, MSK_I26};
   localparam opc_t OPC_BLTU      = '{32'h6800_0000, MSK_I26};
   localparam opc_t OPC_BGEU      = '{32'h6C00_0000, MSK_I26};

   function automatic logic opc_hit(logic [31:0] word, opc_t opc);
      return (word & opc.mask) == opc.match;
   endfunction

endpackage

//--- source/inst_decoder.sv
module inst_decoder import dec_pkg::*; (
   input  logic [DATA_W-1:0] inst,
   output unit_t             unit,
   output alu_op_t           alu_op,
   output lsu_op_t           lsu_op,
   output bru_op_t           bru_op,
   output logic              mul_signed,
   output logic              mul_hi,
   output logic              b_imm,
   output logic              a_pc,
   output logic              a_zero,
   output logic              rd_read,
   output logic              rf_wen,
   output logic              csr_write,
   output logic              csr_xchg,
   output logic [2:0]        imm_sel
);

   // sub-ops inside the mul and csr classes
   localparam logic [3:0] MUL_W    = 4'd0;
   localparam logic [3:0] MULH_W   = 4'd1;
   localparam logic [3:0] MULH_WU  = 4'd2;
   localparam logic [3:0] CSR_RD   = 4'd0;
   localparam logic [3:0] CSR_WR   = 4'd1;
   localparam logic [3:0] CSR_XCHG = 4'd2;

   typedef struct packed {
      unit_t      unit;
      logic [3:0] op;
      logic [2:0] imm;
   } dec_t;

   dec_t d;

   function automatic dec_t pick(unit_t u, logic [3:0] o, logic [2:0] i);
      return '{unit: u, op: o, imm: i};
   endfunction

   // first hit wins, anything else is an unknown word
   always_comb begin
      d = pick(U_NONE, 4'd0, IMM_ZERO);
      if      (opc_hit(inst, OPC_ADD_W))     d = pick(U_ALU, ALU_ADD, IMM_ZERO);
      else if (opc_hit(inst, OPC_SUB_W))     d = pick(U_ALU, ALU_SUB, IMM_ZERO);
      else if (opc_hit(inst, OPC_SLT))       d = pick(U_ALU, ALU_SLT, IMM_ZERO);
      else if (opc_hit(inst, OPC_SLTU))      d = pick(U_ALU, ALU_SLTU, IMM_ZERO);
      else if (opc_hit(inst, OPC_NOR))       d = pick(U_ALU, ALU_NOR, IMM_ZERO);
      else if (opc_hit(inst, OPC_AND))       d = pick(U_ALU, ALU_AND, IMM_ZERO);
      else if (opc_hit(inst, OPC_OR))        d = pick(U_ALU, ALU_OR, IMM_ZERO);
      else if (opc_hit(inst, OPC_XOR))       d = pick(U_ALU, ALU_XOR, IMM_ZERO);
      else if (opc_hit(inst, OPC_SLL_W))     d = pick(U_ALU, ALU_SLL, IMM_ZERO);
      else if (opc_hit(inst, OPC_SRL_W))     d = pick(U_ALU, ALU_SRL, IMM_ZERO);
      else if (opc_hit(inst, OPC_SRA_W))     d = pick(U_ALU, ALU_SRA, IMM_ZERO);
      else if (opc_hit(inst, OPC_MUL_W))     d = pick(U_MUL, MUL_W, IMM_ZERO);
      else if (opc_hit(inst, OPC_MULH_W))    d = pick(U_MUL, MULH_W, IMM_ZERO);
      else if (opc_hit(inst, OPC_MULH_WU))   d = pick(U_MUL, MULH_WU, IMM_ZERO);
      else if (opc_hit(inst, OPC_BREAK))     d = pick(U_BRK, 4'd0, IMM_ZERO);
      else if (opc_hit(inst, OPC_SYSCALL))   d = pick(U_SYS, 4'd0, IMM_ZERO);
      // immediate forms
      else if (opc_hit(inst, OPC_SLLI_W))    d = pick(U_ALU, ALU_SLL, IMM_UI5);
      else if (opc_hit(inst, OPC_SRLI_W))    d = pick(U_ALU, ALU_SRL, IMM_UI5);
      else if (opc_hit(inst, OPC_SRAI_W))    d = pick(U_ALU, ALU_SRA, IMM_UI5);
      else if (opc_hit(inst, OPC_SLTI))      d = pick(U_ALU, ALU_SLT, IMM_SI12);
      else if (opc_hit(inst, OPC_SLTUI))     d = pick(U_ALU, ALU_SLTU, IMM_SI12);
      else if (opc_hit(inst, OPC_ADDI_W))    d = pick(U_ALU, ALU_ADD, IMM_SI12);
      else if (opc_hit(inst, OPC_ANDI))      d = pick(U_ALU, ALU_AND, IMM_UI12);
      else if (opc_hit(inst, OPC_ORI))       d = pick(U_ALU, ALU_OR, IMM_UI12);
      else if (opc_hit(inst, OPC_XORI))      d = pick(U_ALU, ALU_XOR, IMM_UI12);
      else if (opc_hit(inst, OPC_LU12I_W))   d = pick(U_ALU, ALU_LUI, IMM_SI20);
      else if (opc_hit(inst, OPC_PCADDU12I)) d = pick(U_ALU, ALU_ADD, IMM_SI20);
      // csrxchg only after rj 0 and rj 1 are ruled out
      else if (opc_hit(inst, OPC_CSRRD))     d = pick(U_CSR, CSR_RD, IMM_ZERO);
      else if (opc_hit(inst, OPC_CSRWR))     d = pick(U_CSR, CSR_WR, IMM_ZERO);
      else if (opc_hit(inst, OPC_CSRXCHG))   d = pick(U_CSR, CSR_XCHG, IMM_ZERO);
      else if (opc_hit(inst, OPC_ERTN))      d = pick(U_ERTN, 4'd0, IMM_ZERO);
      else if (opc_hit(inst, OPC_LD_B))      d = pick(U_LSU, LSU_LD_B, IMM_SI12);
      else if (opc_hit(inst, OPC_LD_H))      d = pick(U_LSU, LSU_LD_H, IMM_SI12);
      else if (opc_hit(inst, OPC_LD_W))      d = pick(U_LSU, LSU_LD_W, IMM_SI12);
      else if (opc_hit(inst, OPC_ST_B))      d = pick(U_LSU, LSU_ST_B, IMM_SI12);
      else if (opc_hit(inst, OPC_ST_H))      d = pick(U_LSU, LSU_ST_H, IMM_SI12);
      else if (opc_hit(inst, OPC_ST_W))      d = pick(U_LSU, LSU_ST_W, IMM_SI12);
      else if (opc_hit(inst, OPC_LD_BU))     d = pick(U_LSU, LSU_LD_BU, IMM_SI12);
      else if (opc_hit(inst, OPC_LD_HU))     d = pick(U_LSU, LSU_LD_HU, IMM_SI12);
      else if (opc_hit(inst, OPC_JIRL))      d = pick(U_BRU, BRU_JIRL, IMM_ZERO);
      else if (opc_hit(inst, OPC_B))         d = pick(U_BRU, BRU_B, IMM_ZERO);
      else if (opc_hit(inst, OPC_BL))        d = pick(U_BRU, BRU_BL, IMM_ZERO);
      else if (opc_hit(inst, OPC_BEQ))       d = pick(U_BRU, BRU_BEQ, IMM_ZERO);
      else if (opc_hit(inst, OPC_BNE))       d = pick(U_BRU, BRU_BNE, IMM_ZERO);
      else if (opc_hit(inst, OPC_BLT))       d = pick(U_BRU, BRU_BLT, IMM_ZERO);
      else if (opc_hit(inst, OPC_BGE))       d = pick(U_BRU, BRU_BGE, IMM_ZERO);
      else if (opc_hit(inst, OPC_BLTU))      d = pick(U_BRU, BRU_BLTU, IMM_ZERO);
      else if (opc_hit(inst, OPC_BGEU))      d = pick(U_BRU, BRU_BGEU, IMM_ZERO);
   end

   assign unit    = d.unit;
   assign imm_sel = d.imm;

   // unit op codes read zero outside their own class
   assign alu_op = alu_op_t'((d.unit == U_ALU) ? d.op : 4'd0);
   assign lsu_op = lsu_op_t'((d.unit == U_LSU) ? d.op : 4'd0);
   assign bru_op = bru_op_t'((d.unit == U_BRU) ? d.op : 4'd0);

   assign mul_signed = (d.unit == U_MUL) && (d.op != MULH_WU);
   assign mul_hi     = (d.unit == U_MUL) && (d.op != MUL_W);
   assign csr_write  = (d.unit == U_CSR) && (d.op != CSR_RD);
   assign csr_xchg   = (d.unit == U_CSR) && (d.op == CSR_XCHG);

   ////////////////////////////// operand flags
   assign b_imm  = (d.unit == U_ALU) && (d.imm != IMM_ZERO);
   assign a_zero = (d.unit == U_ALU) && (alu_op == ALU_LUI);
   assign a_pc   = (d.unit == U_ALU) && (alu_op == ALU_ADD) && (d.imm == IMM_SI20);

   // rd is a source for stores, compares and the csr write data
   assign rd_read = (d.unit == U_LSU && lsu_op >= LSU_ST_B) ||
                    (d.unit == U_BRU && bru_op < BRU_B) ||
                    (d.unit == U_CSR);

   assign rf_wen = (d.unit == U_ALU) || (d.unit == U_MUL) || (d.unit == U_CSR) ||
                   (d.unit == U_LSU && lsu_op < LSU_ST_B) ||
                   (d.unit == U_BRU && (bru_op == BRU_BL || bru_op == BRU_JIRL));

endmodule

//--- source/imm_gen.sv
module imm_gen import dec_pkg::*; (
   input  logic [DATA_W-1:0] inst,
   input  logic [2:0]        imm_sel,
   input  bru_op_t           bru_op,
   output logic [DATA_W-1:0] imm_shifted,
   output logic [DATA_W-1:0] br_offset
);

   always_comb begin
      case (imm_sel)
         IMM_SI12: imm_shifted = {{(DATA_W-12){inst[21]}}, inst[21:10]};
         IMM_UI12: imm_shifted = {{(DATA_W-12){1'b0}}, inst[21:10]};
         IMM_UI5:  imm_shifted = {{(DATA_W-5){1'b0}}, inst[14:10]};
         IMM_SI20: imm_shifted = {inst[24:5], 12'd0};
         default:  imm_shifted = '0;
      endcase
   end

   // b and bl carry offs26 with its high part in bits 9-0
   assign br_offset = (bru_op == BRU_B || bru_op == BRU_BL) ?
                      {{(DATA_W-28){inst[9]}}, inst[9:0], inst[25:10], 2'b00} :
                      {{(DATA_W-18){inst[25]}}, inst[25:10], 2'b00};

endmodule

//--- source/dispatch_ctrl.sv
module dispatch_ctrl import dec_pkg::*; (
   input  unit_t            unit,
   input  logic             inst_vld,
   input  logic             rf_wen,
   input  logic             csr_write,
   output logic             exception,
   output logic             alu_disp,
   output logic [EXC_W-1:0] exccode,
   output logic             lsu_valid,
   output logic             bru_valid,
   output logic             mul_valid,
   output logic             csr_valid,
   output logic             ertn_valid,
   output logic             alu_wen,
   output logic             lsu_wen,
   output logic             mul_wen,
   output logic             csr_rdwen,
   output logic             csr_wen
);

   logic exc_lvl;
   logic go;

   assign exc_lvl = (unit == U_SYS) || (unit == U_BRK) || (unit == U_NONE);

   assign exccode = (unit == U_SYS)  ? EXC_SYS :
                    (unit == U_BRK)  ? EXC_BRK :
                    (unit == U_NONE) ? EXC_INE :
                                       '0;

   assign exception = exc_lvl & inst_vld;

   // nothing dispatches when killed or trapping
   assign go = inst_vld & ~exc_lvl;

   // branches share the alu write port for the link register
   assign alu_disp   = go && (unit == U_ALU || unit == U_BRU);
   assign lsu_valid  = go && (unit == U_LSU);
   assign bru_valid  = go && (unit == U_BRU);
   assign mul_valid  = go && (unit == U_MUL);
   assign csr_valid  = go && (unit == U_CSR);
   assign ertn_valid = go && (unit == U_ERTN);

   ////////////////////////////// write enables
   assign alu_wen   = rf_wen & alu_disp;
   assign lsu_wen   = rf_wen & lsu_valid;
   assign mul_wen   = rf_wen & mul_valid;
   assign csr_rdwen = rf_wen & csr_valid;
   assign csr_wen   = csr_write & csr_valid;

endmodule

//--- source/operand_sel.sv
module operand_sel import dec_pkg::*; (
   input  logic [DATA_W-1:0] inst,
   input  logic [DATA_W-1:0] pc,
   input  logic [DATA_W-1:0] rs1_data,
   input  logic [DATA_W-1:0] rs2_data,
   input  logic [DATA_W-1:0] imm_shifted,
   input  logic              rd_read,
   input  logic              a_pc,
   input  logic              a_zero,
   input  logic              b_imm,
   input  logic              alu_disp,
   input  bru_op_t           bru_op,
   output logic [REG_W-1:0]  rs1,
   output logic [REG_W-1:0]  rs2,
   output logic [REG_W-1:0]  rf_target,
   output logic [DATA_W-1:0] alu_a,
   output logic [DATA_W-1:0] alu_b
);

   assign rs1 = inst[9:5];
   assign rs2 = rd_read ? inst[4:0] : inst[14:10];

   // bl links into r1
   assign rf_target = (bru_op == BRU_BL) ? REG_W'(1) : inst[4:0];

   assign alu_a = a_zero ? '0 :
                  a_pc   ? pc :
                           rs1_data;

   assign alu_b = (b_imm & alu_disp) ? imm_shifted : rs2_data;

endmodule

//--- source/d2e_stage.sv
module d2e_stage import dec_pkg::*; (
   input  logic              clk,
   input  logic              arst_n,
   input  logic [DATA_W-1:0] alu_a_d,
   input  logic [DATA_W-1:0] alu_b_d,
   input  alu_op_t           alu_op_d,
   input  logic [REG_W-1:0]  rs1_d,
   input  logic [REG_W-1:0]  rs2_d,
   input  logic [REG_W-1:0]  rf_target_d,
   input  lsu_op_t           lsu_op_d,
   input  logic [DATA_W-1:0] imm_shifted_d,
   input  bru_op_t           bru_op_d,
   input  logic [DATA_W-1:0] bru_offset_d,
   input  logic              mul_signed_d,
   input  logic              mul_hi_d,
   input  logic              csr_xchg_d,
   input  logic [CSR_W-1:0]  csr_waddr_d,
   input  logic [EXC_W-1:0]  exccode_d,
   // strobes
   input  logic              alu_wen_d, lsu_valid_d, lsu_wen_d, bru_valid_d,
   input  logic              mul_valid_d, mul_wen_d, csr_valid_d, csr_rdwen_d,
   input  logic              csr_wen_d, ertn_valid_d, exception_d,
   output logic [DATA_W-1:0] alu_a_e,
   output logic [DATA_W-1:0] alu_b_e,
   output alu_op_t           alu_op_e,
   output logic [REG_W-1:0]  rs1_e,
   output logic [REG_W-1:0]  rs2_e,
   output logic [REG_W-1:0]  rf_target_e,
   output lsu_op_t           lsu_op_e,
   output logic [DATA_W-1:0] imm_shifted_e,
   output logic [REG_W-1:0]  lsu_rd_e,
   output bru_op_t           bru_op_e,
   output logic [DATA_W-1:0] bru_offset_e,
   output logic              mul_signed_e,
   output logic              mul_hi_e,
   output logic              csr_xchg_e,
   output logic [CSR_W-1:0]  csr_waddr_e,
   output logic [EXC_W-1:0]  exccode_e,
   output logic              alu_wen_e, lsu_valid_e, lsu_wen_e, bru_valid_e,
   output logic              mul_valid_e, mul_wen_e, csr_valid_e, csr_rdwen_e,
   output logic              csr_wen_e, ertn_valid_e, exception_e
);

   ////////////////////////////// control strobes
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         alu_wen_e    <= 1'b0;
         lsu_valid_e  <= 1'b0;
         lsu_wen_e    <= 1'b0;
         bru_valid_e  <= 1'b0;
         mul_valid_e  <= 1'b0;
         mul_wen_e    <= 1'b0;
         csr_valid_e  <= 1'b0;
         csr_rdwen_e  <= 1'b0;
         csr_wen_e    <= 1'b0;
         ertn_valid_e <= 1'b0;
         exception_e  <= 1'b0;
      end else begin
         alu_wen_e    <= alu_wen_d;
         lsu_valid_e  <= lsu_valid_d;
         lsu_wen_e    <= lsu_wen_d;
         bru_valid_e  <= bru_valid_d;
         mul_valid_e  <= mul_valid_d;
         mul_wen_e    <= mul_wen_d;
         csr_valid_e  <= csr_valid_d;
         csr_rdwen_e  <= csr_rdwen_d;
         csr_wen_e    <= csr_wen_d;
         ertn_valid_e <= ertn_valid_d;
         exception_e  <= exception_d;
      end
   end

   ////////////////////////////// payload
   always_ff @(posedge clk) begin
      alu_a_e       <= alu_a_d;
      alu_b_e       <= alu_b_d;
      alu_op_e      <= alu_op_d;
      rs1_e         <= rs1_d;
      rs2_e         <= rs2_d;
      rf_target_e   <= rf_target_d;
      lsu_op_e      <= lsu_op_d;
      imm_shifted_e <= imm_shifted_d;
      // load target is the same rd field
      lsu_rd_e      <= rf_target_d;
      bru_op_e      <= bru_op_d;
      bru_offset_e  <= bru_offset_d;
      mul_signed_e  <= mul_signed_d;
      mul_hi_e      <= mul_hi_d;
      csr_xchg_e    <= csr_xchg_d;
      csr_waddr_e   <= csr_waddr_d;
      exccode_e     <= exccode_d;
   end

endmodule

//--- source/ifu_dec.sv
module ifu_dec import dec_pkg::*; (
   input  logic              clk,
   input  logic              arst_n,
   input  logic              inst_vld_d,
   input  logic [DATA_W-1:0] inst_d,
   input  logic [DATA_W-1:0] pc_d,
   input  logic [DATA_W-1:0] rs1_data_d,
   input  logic [DATA_W-1:0] rs2_data_d,
   output logic [REG_W-1:0]  rs1_d,
   output logic [REG_W-1:0]  rs2_d,
   output logic [CSR_W-1:0]  csr_raddr_d,
   // alu
   output logic [DATA_W-1:0] alu_a_e, alu_b_e,
   output alu_op_t           alu_op_e,
   output logic [REG_W-1:0]  rs1_e, rs2_e, rf_target_e,
   output logic              alu_wen_e,
   // lsu
   output logic              lsu_valid_e, lsu_wen_e,
   output lsu_op_t           lsu_op_e,
   output logic [DATA_W-1:0] imm_shifted_e,
   output logic [REG_W-1:0]  lsu_rd_e,
   // bru
   output logic              bru_valid_e,
   output bru_op_t           bru_op_e,
   output logic [DATA_W-1:0] bru_offset_e,
   // mul
   output logic              mul_valid_e, mul_wen_e, mul_signed_e, mul_hi_e,
   // csr
   output logic              csr_valid_e, csr_rdwen_e, csr_xchg_e, csr_wen_e,
   output logic [CSR_W-1:0]  csr_waddr_e,
   // ertn and exceptions
   output logic              ertn_valid_e, exception_e,
   output logic [EXC_W-1:0]  exccode_e
);

   unit_t             unit_d;
   alu_op_t           alu_op_d;
   lsu_op_t           lsu_op_d;
   bru_op_t           bru_op_d;
   logic [2:0]        imm_sel_d;
   logic [DATA_W-1:0] imm_shifted_d, bru_offset_d, alu_a_d, alu_b_d;
   logic [REG_W-1:0]  rf_target_d;
   logic [EXC_W-1:0]  exccode_d;
   logic              mul_signed_d, mul_hi_d, b_imm_d, a_pc_d, a_zero_d;
   logic              rd_read_d, rf_wen_d, csr_write_d, csr_xchg_d;
   logic              exception_d, alu_disp_d, lsu_valid_d, bru_valid_d;
   logic              mul_valid_d, csr_valid_d, ertn_valid_d;
   logic              alu_wen_d, lsu_wen_d, mul_wen_d, csr_rdwen_d, csr_wen_d;

   // csr number goes straight out for the same-cycle read
   assign csr_raddr_d = inst_d[23:10];

   inst_decoder u_decoder (
      .inst(inst_d), .unit(unit_d), .alu_op(alu_op_d), .lsu_op(lsu_op_d),
      .bru_op(bru_op_d), .mul_signed(mul_signed_d), .mul_hi(mul_hi_d),
      .b_imm(b_imm_d), .a_pc(a_pc_d), .a_zero(a_zero_d), .rd_read(rd_read_d),
      .rf_wen(rf_wen_d), .csr_write(csr_write_d), .csr_xchg(csr_xchg_d),
      .imm_sel(imm_sel_d)
   );

   imm_gen u_imm_gen (
      .inst(inst_d), .imm_sel(imm_sel_d), .bru_op(bru_op_d),
      .imm_shifted(imm_shifted_d), .br_offset(bru_offset_d)
   );

   dispatch_ctrl u_dispatch (
      .unit(unit_d), .inst_vld(inst_vld_d), .rf_wen(rf_wen_d), .csr_write(csr_write_d),
      .exception(exception_d), .alu_disp(alu_disp_d), .exccode(exccode_d),
      .lsu_valid(lsu_valid_d), .bru_valid(bru_valid_d), .mul_valid(mul_valid_d),
      .csr_valid(csr_valid_d), .ertn_valid(ertn_valid_d), .alu_wen(alu_wen_d),
      .lsu_wen(lsu_wen_d), .mul_wen(mul_wen_d), .csr_rdwen(csr_rdwen_d),
      .csr_wen(csr_wen_d)
   );

   operand_sel u_operand (
      .inst(inst_d), .pc(pc_d), .rs1_data(rs1_data_d), .rs2_data(rs2_data_d),
      .imm_shifted(imm_shifted_d), .rd_read(rd_read_d), .a_pc(a_pc_d),
      .a_zero(a_zero_d), .b_imm(b_imm_d), .alu_disp(alu_disp_d), .bru_op(bru_op_d),
      .rs1(rs1_d), .rs2(rs2_d), .rf_target(rf_target_d),
      .alu_a(alu_a_d), .alu_b(alu_b_d)
   );

   // remaining d2e ports share their names with the wires above
   d2e_stage u_d2e (
      .csr_waddr_d(csr_raddr_d),
      .*
   );

endmodule

//--- test/tb_ifu_dec_ref.svh
`ifndef TB_IFU_DEC_REF_SVH
`define TB_IFU_DEC_REF_SVH

// one entry per kept instruction, sub-op for mul is 0 mul.w, 1 mulh.w, 2 mulh.wu
// and for csr 0 csrrd, 1 csrwr, 2 csrxchg
typedef struct packed {
   opc_t       opc;
   unit_t      u;
   logic [3:0] op;
   logic [2:0] imm;
} kept_t;

typedef struct packed {
   logic [4:0]  rs1, rs2, rf_target;
   logic [13:0] csr_raddr;
   logic [31:0] alu_a, alu_b, imm, br_off;
   logic [3:0]  alu_op, lsu_op, bru_op;
   logic [5:0]  exccode;
   logic mul_signed, mul_hi, csr_xchg, alu_wen, lsu_valid, lsu_wen, bru_valid;
   logic mul_valid, mul_wen, csr_valid, csr_rdwen, csr_wen, ertn_valid, exception;
} exp_t;

localparam int NKEPT = 48;

// csrrd and csrwr must be found before csrxchg
localparam kept_t KEPT [NKEPT] = '{
   '{OPC_ADD_W, U_ALU, ALU_ADD, IMM_ZERO}, '{OPC_SUB_W, U_ALU, ALU_SUB, IMM_ZERO},
   '{OPC_SLT, U_ALU, ALU_SLT, IMM_ZERO}, '{OPC_SLTU, U_ALU, ALU_SLTU, IMM_ZERO},
   '{OPC_NOR, U_ALU, ALU_NOR, IMM_ZERO}, '{OPC_AND, U_ALU, ALU_AND, IMM_ZERO},
   '{OPC_OR, U_ALU, ALU_OR, IMM_ZERO}, '{OPC_XOR, U_ALU, ALU_XOR, IMM_ZERO},
   '{OPC_SLL_W, U_ALU, ALU_SLL, IMM_ZERO}, '{OPC_SRL_W, U_ALU, ALU_SRL, IMM_ZERO},
   '{OPC_SRA_W, U_ALU, ALU_SRA, IMM_ZERO}, '{OPC_MUL_W, U_MUL, 4'd0, IMM_ZERO},
   '{OPC_MULH_W, U_MUL, 4'd1, IMM_ZERO}, '{OPC_MULH_WU, U_MUL, 4'd2, IMM_ZERO},
   '{OPC_BREAK, U_BRK, 4'd0, IMM_ZERO}, '{OPC_SYSCALL, U_SYS, 4'd0, IMM_ZERO},
   '{OPC_SLLI_W, U_ALU, ALU_SLL, IMM_UI5}, '{OPC_SRLI_W, U_ALU, ALU_SRL, IMM_UI5},
   '{OPC_SRAI_W, U_ALU, ALU_SRA, IMM_UI5}, '{OPC_SLTI, U_ALU, ALU_SLT, IMM_SI12},
   '{OPC_SLTUI, U_ALU, ALU_SLTU, IMM_SI12}, '{OPC_ADDI_W, U_ALU, ALU_ADD, IMM_SI12},
   '{OPC_ANDI, U_ALU, ALU_AND, IMM_UI12}, '{OPC_ORI, U_ALU, ALU_OR, IMM_UI12},
   '{OPC_XORI, U_ALU, ALU_XOR, IMM_UI12}, '{OPC_LU12I_W, U_ALU, ALU_LUI, IMM_SI20},
   '{OPC_PCADDU12I, U_ALU, ALU_ADD, IMM_SI20}, '{OPC_CSRRD, U_CSR, 4'd0, IMM_ZERO},
   '{OPC_CSRWR, U_CSR, 4'd1, IMM_ZERO}, '{OPC_CSRXCHG, U_CSR, 4'd2, IMM_ZERO},
   '{OPC_ERTN, U_ERTN, 4'd0, IMM_ZERO}, '{OPC_LD_B, U_LSU, LSU_LD_B, IMM_SI12},
   '{OPC_LD_H, U_LSU, LSU_LD_H, IMM_SI12}, '{OPC_LD_W, U_LSU, LSU_LD_W, IMM_SI12},
   '{OPC_ST_B, U_LSU, LSU_ST_B, IMM_SI12}, '{OPC_ST_H, U_LSU, LSU_ST_H, IMM_SI12},
   '{OPC_ST_W, U_LSU, LSU_ST_W, IMM_SI12}, '{OPC_LD_BU, U_LSU, LSU_LD_BU, IMM_SI12},
   '{OPC_LD_HU, U_LSU, LSU_LD_HU, IMM_SI12}, '{OPC_JIRL, U_BRU, BRU_JIRL, IMM_ZERO},
   '{OPC_B, U_BRU, BRU_B, IMM_ZERO}, '{OPC_BL, U_BRU, BRU_BL, IMM_ZERO},
   '{OPC_BEQ, U_BRU, BRU_BEQ, IMM_ZERO}, '{OPC_BNE, U_BRU, BRU_BNE, IMM_ZERO},
   '{OPC_BLT, U_BRU, BRU_BLT, IMM_ZERO}, '{OPC_BGE, U_BRU, BRU_BGE, IMM_ZERO},
   '{OPC_BLTU, U_BRU, BRU_BLTU, IMM_ZERO}, '{OPC_BGEU, U_BRU, BRU_BGEU, IMM_ZERO}
};

// kept instruction with every free field random
function automatic logic [31:0] build_inst(int idx, logic [31:0] fields);
   return KEPT[idx].opc.match | (fields & ~KEPT[idx].opc.mask);
endfunction

function automatic exp_t ref_decode(logic [31:0] w, logic [31:0] pc, logic [31:0] r1d,
                                    logic [31:0] r2d, logic vld);
   exp_t        e;
   kept_t       k;
   logic        found, store, cond_br, link, rfw, rdr, exc, go, is_alu, is_bru;
   logic [25:0] o26;
   k = '{'{32'h0, 32'h0}, U_NONE, 4'd0, IMM_ZERO};
   found = 1'b0;
   for (int i = 0; i < NKEPT; i++) begin
      if (!found && (w & KEPT[i].opc.mask) == KEPT[i].opc.match) begin
         k = KEPT[i];
         found = 1'b1;
      end
   end
   is_alu  = (k.u == U_ALU);
   is_bru  = (k.u == U_BRU);
   store   = (k.u == U_LSU) && (k.op >= 4'd5);
   cond_br = is_bru && (k.op < 4'd6);
   link    = is_bru && (k.op == 4'd7 || k.op == 4'd8);
   rfw     = is_alu || k.u == U_MUL || k.u == U_CSR || (k.u == U_LSU && !store) || link;
   rdr     = store || cond_br || k.u == U_CSR;
   exc     = (k.u == U_SYS) || (k.u == U_BRK) || (k.u == U_NONE);
   go      = vld && !exc;
   e.rs1       = w[9:5];
   e.rs2       = rdr ? w[4:0] : w[14:10];
   e.csr_raddr = w[23:10];
   case (k.imm)
      IMM_SI12: e.imm = {{20{w[21]}}, w[21:10]};
      IMM_UI12: e.imm = {20'd0, w[21:10]};
      IMM_UI5:  e.imm = {27'd0, w[14:10]};
      IMM_SI20: e.imm = {w[24:5], 12'd0};
      default:  e.imm = 32'd0;
   endcase
   e.alu_op = is_alu ? k.op : 4'd0;
   e.lsu_op = (k.u == U_LSU) ? k.op : 4'd0;
   e.bru_op = is_bru ? k.op : 4'd0;
   o26 = {w[9:0], w[25:10]};
   e.br_off = (is_bru && (k.op == 4'd6 || k.op == 4'd7)) ? {{4{o26[25]}}, o26, 2'b00} :
              {{14{w[25]}}, w[25:10], 2'b00};
   e.alu_a = (k.opc == OPC_LU12I_W) ? 32'd0 : (k.opc == OPC_PCADDU12I) ? pc : r1d;
   e.alu_b = (is_alu && go && k.imm != IMM_ZERO) ? e.imm : r2d;
   e.rf_target  = (is_bru && k.op == 4'd7) ? 5'd1 : w[4:0];
   e.mul_signed = (k.u == U_MUL) && (k.op != 4'd2);
   e.mul_hi     = (k.u == U_MUL) && (k.op != 4'd0);
   e.csr_xchg   = (k.u == U_CSR) && (k.op == 4'd2);
   // link writes go through the alu port
   e.alu_wen    = go && rfw && (is_alu || is_bru);
   e.lsu_valid  = go && (k.u == U_LSU);
   e.lsu_wen    = e.lsu_valid && rfw;
   e.bru_valid  = go && is_bru;
   e.mul_valid  = go && (k.u == U_MUL);
   e.mul_wen    = e.mul_valid && rfw;
   e.csr_valid  = go && (k.u == U_CSR);
   e.csr_rdwen  = e.csr_valid && rfw;
   e.csr_wen    = e.csr_valid && (k.op != 4'd0);
   e.ertn_valid = go && (k.u == U_ERTN);
   e.exception  = exc && vld;
   e.exccode    = (k.u == U_SYS) ? 6'h0B : (k.u == U_BRK) ? 6'h0C :
                  (k.u == U_NONE) ? 6'h0D : 6'h00;
   return e;
endfunction

`endif

//--- test/tb_ifu_dec.sv
module tb_ifu_dec import dec_pkg::*; ();

   `include "tb_ifu_dec_ref.svh"

   localparam int RST_CYCLES = 4;
   localparam int NUM_TESTS  = 3000;

   logic              clk, arst_n, inst_vld_d;
   logic [DATA_W-1:0] inst_d, pc_d, rs1_data_d, rs2_data_d;
   logic [REG_W-1:0]  rs1_d, rs2_d, rs1_e, rs2_e, rf_target_e, lsu_rd_e;
   logic [CSR_W-1:0]  csr_raddr_d, csr_waddr_e;
   logic [DATA_W-1:0] alu_a_e, alu_b_e, imm_shifted_e, bru_offset_e;
   alu_op_t           alu_op_e;
   lsu_op_t           lsu_op_e;
   bru_op_t           bru_op_e;
   logic [EXC_W-1:0]  exccode_e;
   logic alu_wen_e, lsu_valid_e, lsu_wen_e, bru_valid_e, mul_valid_e, mul_wen_e;
   logic mul_signed_e, mul_hi_e, csr_valid_e, csr_rdwen_e, csr_xchg_e, csr_wen_e;
   logic ertn_valid_e, exception_e;

   integer seed;
   exp_t   cur, prev;
   logic   prev_loaded;

   ifu_dec u_ifu_dec (.*);

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   task automatic check_val(string name, logic [31:0] act, logic [31:0] exp);
      if (act !== exp) begin
         $display("** Error at %0t: %s is %h, expected %h", $time, name, act, exp);
         $display("*** TEST FAILED ***");
         $fatal(1);
      end
   endtask

   task automatic drive_random();
      logic [31:0] r;
      r = $random(seed);
      if ($unsigned(r) % 10 == 0)
         inst_d = $random(seed);
      else
         inst_d = build_inst($unsigned($random(seed)) % NKEPT, $random(seed));
      inst_vld_d = ($unsigned($random(seed)) % 10) < 8;
      pc_d       = $random(seed);
      rs1_data_d = $random(seed);
      rs2_data_d = $random(seed);
   endtask

   task automatic check_strobes(exp_t e);
      check_val("alu_wen_e", alu_wen_e, e.alu_wen);
      check_val("lsu_valid_e", lsu_valid_e, e.lsu_valid);
      check_val("lsu_wen_e", lsu_wen_e, e.lsu_wen);
      check_val("bru_valid_e", bru_valid_e, e.bru_valid);
      check_val("mul_valid_e", mul_valid_e, e.mul_valid);
      check_val("mul_wen_e", mul_wen_e, e.mul_wen);
      check_val("csr_valid_e", csr_valid_e, e.csr_valid);
      check_val("csr_rdwen_e", csr_rdwen_e, e.csr_rdwen);
      check_val("csr_wen_e", csr_wen_e, e.csr_wen);
      check_val("ertn_valid_e", ertn_valid_e, e.ertn_valid);
      check_val("exception_e", exception_e, e.exception);
   endtask

   task automatic check_payload(exp_t e);
      check_val("alu_a_e", alu_a_e, e.alu_a);
      check_val("alu_b_e", alu_b_e, e.alu_b);
      check_val("alu_op_e", alu_op_e, e.alu_op);
      check_val("rs1_e", rs1_e, e.rs1);
      check_val("rs2_e", rs2_e, e.rs2);
      check_val("rf_target_e", rf_target_e, e.rf_target);
      check_val("lsu_op_e", lsu_op_e, e.lsu_op);
      check_val("imm_shifted_e", imm_shifted_e, e.imm);
      check_val("lsu_rd_e", lsu_rd_e, e.rf_target);
      check_val("bru_op_e", bru_op_e, e.bru_op);
      check_val("bru_offset_e", bru_offset_e, e.br_off);
      check_val("mul_signed_e", mul_signed_e, e.mul_signed);
      check_val("mul_hi_e", mul_hi_e, e.mul_hi);
      check_val("csr_xchg_e", csr_xchg_e, e.csr_xchg);
      check_val("csr_waddr_e", csr_waddr_e, e.csr_raddr);
      check_val("exccode_e", exccode_e, e.exccode);
   endtask

   ////////////////////////////// compare
   // inputs and outputs are settled mid-cycle
   initial begin
      prev_loaded = 1'b0;
      @(posedge clk);
      forever begin
         @(negedge clk);
         if (prev_loaded) begin
            check_strobes(prev);
            check_payload(prev);
         end else begin
            check_strobes('0);
         end
         cur = ref_decode(inst_d, pc_d, rs1_data_d, rs2_data_d, inst_vld_d);
         check_val("rs1_d", rs1_d, cur.rs1);
         check_val("rs2_d", rs2_d, cur.rs2);
         check_val("csr_raddr_d", csr_raddr_d, cur.csr_raddr);
         prev = cur;
         prev_loaded = arst_n;
      end
   end

   ////////////////////////////// stimulus
   initial begin
      seed       = 17316;
      arst_n     = 1'b0;
      inst_vld_d = 1'b0;
      inst_d     = '0;
      pc_d       = '0;
      rs1_data_d = '0;
      rs2_data_d = '0;
      repeat (RST_CYCLES) begin
         @(posedge clk);
         #2 drive_random();
      end
      arst_n = 1'b1;
      repeat (NUM_TESTS) begin
         @(posedge clk);
         #2 drive_random();
      end
      // last instruction is checked at the negedge before the second edge
      repeat (2) @(posedge clk);
      $display("*** TEST PASSED ***");
      $finish;
   end

   // watchdog
   initial begin
      #((RST_CYCLES + NUM_TESTS + 10) * 40);
      $display("timeout: the run did not finish in time");
      $display("*** TEST FAILED ***");
      $fatal(1);
   end

endmodule

//--- all.f
+incdir+test
source/dec_pkg.sv
source/inst_decoder.sv
source/imm_gen.sv
source/dispatch_ctrl.sv
source/operand_sel.sv
source/d2e_stage.sv
source/ifu_dec.sv
test/tb_ifu_dec.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing -Wno-fatal
TOP       ?= tb_ifu_dec
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "\*\*\* TEST PASSED \*\*\*" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
